// ==== Bender.yml ====
package:
  name: cpu_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_subsys_pkg.sv
      - rtl/irq_sync.sv
      - rtl/ahb_rom_bridge.sv
      - rtl/boot_rom.sv
      - rtl/ahb_addr_decoder.sv
      - rtl/cpu_subsystem.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tests/cpu_subsystem_tb.sv

// ==== cpu_subsystem.f ====
+incdir+rtl
rtl/cpu_subsys_pkg.sv
rtl/irq_sync.sv
rtl/ahb_rom_bridge.sv
rtl/boot_rom.sv
rtl/ahb_addr_decoder.sv
rtl/cpu_subsystem.sv
tests/cpu_subsystem_tb.sv

// ==== rtl/ahb_addr_decoder.sv ====
// address decode for the upstream AHB port, tracks the data-phase owner and muxes the response
`timescale 1ns/1ps
`default_nettype none
`include "cpu_subsys_defines.svh"

module ahb_addr_decoder
    import cpu_subsys_pkg::*;
(
    input  logic        hclk,
    input  logic        hresetn,
    input  logic [31:0] haddr,
    input  htrans_e     htrans,
    output logic        rom_sel,
    output logic        hsel,
    input  logic        rom_hreadyout,
    input  hresp_e      rom_hresp,
    input  logic [31:0] rom_rdata,
    input  logic        ext_hready,
    input  hresp_e      ext_hresp,
    input  logic [31:0] ext_hrdata,
    output logic        us_hready,
    output hresp_e      us_hresp,
    output logic [31:0] us_hrdata
);

    slave_sel_e owner_q;
    slave_sel_e sel_nxt;
    logic       active;

    assign active  = (htrans == TRANS_NONSEQ) || (htrans == TRANS_SEQ);
    assign rom_sel = active && (haddr[31:16] == `ROM_ADDR_TAG);
    assign hsel    = active && (haddr[31:16] <  `ROM_ADDR_TAG);

    assign sel_nxt = rom_sel ? SEL_ROM : (hsel ? SEL_EXT : SEL_NONE);

    // owner advances only when the current data phase completes
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            owner_q <= SEL_NONE;
        end else if (us_hready) begin
            owner_q <= sel_nxt;
        end
    end

    always_comb begin
        case (owner_q)
            SEL_ROM: begin
                us_hready = rom_hreadyout;
                us_hresp  = rom_hresp;
                us_hrdata = rom_rdata;
            end
            SEL_EXT: begin
                us_hready = ext_hready;
                us_hresp  = ext_hresp;
                us_hrdata = ext_hrdata;
            end
            default: begin
                us_hready = 1'b1;                   // idle data phase
                us_hresp  = RESP_OKAY;
                us_hrdata = '0;
            end
        endcase
    end

    sel_exclusive: assert property (@(posedge hclk) disable iff (!hresetn)
        !(rom_sel && hsel));

    owner_holds_in_wait: assert property (@(posedge hclk) disable iff (!hresetn)
        (owner_q != $past(owner_q)) |-> $past(us_hready));

endmodule

`default_nettype wire

// ==== rtl/ahb_rom_bridge.sv ====
// AHB slave in front of the boot ROM, reads map to chip select, writes get an ERROR response
`timescale 1ns/1ps
`default_nettype none
`include "cpu_subsys_defines.svh"

module ahb_rom_bridge
    import cpu_subsys_pkg::*;
(
    input  logic               hclk,
    input  logic               hresetn,
    input  logic               sel,
    input  logic               ready,
    input  htrans_e            htrans,
    input  logic               hwrite,
    input  logic [15:0]        haddr,
    output logic               hreadyout,
    output hresp_e             hresp,
    output logic               rom_ce,
    output logic [`ROM_AW-1:0] rom_addr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ERR1,
        ST_ERR2
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   xfer;
    logic   wr_xfer;

    // transfer accepted this cycle
    assign xfer    = sel && ready && (htrans == TRANS_NONSEQ || htrans == TRANS_SEQ);
    assign wr_xfer = xfer && hwrite;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (wr_xfer) begin
                    state_d = ST_ERR1;
                end
            end
            ST_ERR1: begin
                state_d = ST_ERR2;                  // second error cycle
            end
            ST_ERR2: begin
                if (wr_xfer) begin
                    state_d = ST_ERR1;              // master kept a ROM write going
                end else begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign hreadyout = (state_q != ST_ERR1);
    assign hresp     = (state_q == ST_IDLE) ? RESP_OKAY : RESP_ERROR;

    // ROM samples the word at the end of the address phase
    assign rom_ce   = xfer && !hwrite;
    assign rom_addr = haddr[`ROM_AW+1:2];

    // wait cycle is ERR1 and is always followed by the closing ERROR cycle
    err_two_cycle: assert property (@(posedge hclk) disable iff (!hresetn)
        !hreadyout |-> (state_q == ST_ERR1 && hresp == RESP_ERROR)
                       ##1 (hreadyout && hresp == RESP_ERROR));

    no_ce_on_write: assert property (@(posedge hclk) disable iff (!hresetn)
        $rose(rom_ce) |-> !hwrite);

endmodule

`default_nettype wire

// ==== rtl/boot_rom.sv ====
// boot ROM model, preloaded from a hex image, one-cycle registered read on chip enable
`timescale 1ns/1ps
`default_nettype none
`include "cpu_subsys_defines.svh"

module boot_rom (
    input  logic               hclk,
    input  logic               ce,
    input  logic [`ROM_AW-1:0] addr,
    output logic [31:0]        rdata
);

    logic [31:0] mem [`ROM_WORDS];

    initial begin
        for (int i = 0; i < `ROM_WORDS; i++) begin
            mem[i] = '0;                            // unlisted words read as zero
        end
        $readmemh("tests/boot_rom.hex", mem);
    end

    // data held until the next enabled read
    always_ff @(posedge hclk) begin
        if (ce) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_subsys_defines.svh ====
// address map and sizing constants for the CPU subsystem, included by RTL and testbench
`ifndef CPU_SUBSYS_DEFINES_SVH
`define CPU_SUBSYS_DEFINES_SVH

// haddr[31:16] value that maps to the boot ROM
`define ROM_ADDR_TAG 16'hFFFF

// ROM word address width, 16384 x 32 = 64 KB
`define ROM_AW 14

// number of ROM words
`define ROM_WORDS (1 << `ROM_AW)

// external interrupt sources, int_src[IRQ_NUM:1]
`define IRQ_NUM 30

// flops in each synchronizer chain
`define SYNC_STAGES 2

`endif

// ==== rtl/cpu_subsys_pkg.sv ====
// shared AHB and slave-select enums, imported by the bus-side RTL and the testbench
`default_nettype none

package cpu_subsys_pkg;

    // AHB transfer type, encoded as on the htrans wires
    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,
        TRANS_BUSY   = 2'b01,
        TRANS_NONSEQ = 2'b10,
        TRANS_SEQ    = 2'b11
    } htrans_e;

    // AHB response, full 2-bit encoding kept on the upstream port
    typedef enum logic [1:0] {
        RESP_OKAY  = 2'b00,
        RESP_ERROR = 2'b01,
        RESP_RETRY = 2'b10,
        RESP_SPLIT = 2'b11
    } hresp_e;

    // which slave owns the current data phase
    typedef enum logic [1:0] {
        SEL_NONE = 2'b00,
        SEL_ROM  = 2'b01,
        SEL_EXT  = 2'b10
    } slave_sel_e;

endpackage

`default_nettype wire

// ==== rtl/cpu_subsystem.sv ====
// bus and interrupt top of the CPU subsystem, the core master port is brought out to the pins
`timescale 1ns/1ps
`default_nettype none
`include "cpu_subsys_defines.svh"

module cpu_subsystem
    import cpu_subsys_pkg::*;
(
    input  logic               hclk,
    input  logic               hresetn,
    // upstream master port
    input  logic [31:0]        us_haddr,
    input  htrans_e            us_htrans,
    input  logic               us_hwrite,
    input  logic [2:0]         us_hsize,
    input  logic [2:0]         us_hburst,
    input  logic [3:0]         us_hprot,
    input  logic [31:0]        us_hwdata,
    output logic [31:0]        us_hrdata,
    output logic               us_hready,
    output hresp_e             us_hresp,
    // external AHB port
    output logic [31:0]        haddr,
    output logic               hsel,
    output htrans_e            htrans,
    output logic               hwrite,
    output logic [2:0]         hsize,
    output logic [2:0]         hburst,
    output logic [3:0]         hprot,
    output logic [31:0]        hwdata,
    input  logic [31:0]        hrdata,
    input  logic               hready,
    input  hresp_e             hresp,
    // interrupts
    input  logic [`IRQ_NUM:1]  int_src,
    input  logic               nmi,
    output logic [`IRQ_NUM:1]  irq_level,
    output logic               nmi_req
);

    logic               rom_sel;
    logic               rom_hreadyout;
    hresp_e             rom_hresp;
    logic               rom_ce;
    logic [`ROM_AW-1:0] rom_addr;
    logic [31:0]        rom_rdata;

    // external port sees the master's address phase unchanged, qualified by hsel
    assign haddr  = us_haddr;
    assign htrans = us_htrans;
    assign hwrite = us_hwrite;
    assign hsize  = us_hsize;
    assign hburst = us_hburst;
    assign hprot  = us_hprot;
    assign hwdata = us_hwdata;

    ahb_addr_decoder u_decoder (
        .hclk          (hclk         ),
        .hresetn       (hresetn      ),
        .haddr         (us_haddr     ),
        .htrans        (us_htrans    ),
        .rom_sel       (rom_sel      ),
        .hsel          (hsel         ),
        .rom_hreadyout (rom_hreadyout),
        .rom_hresp     (rom_hresp    ),
        .rom_rdata     (rom_rdata    ),
        .ext_hready    (hready       ),
        .ext_hresp     (hresp        ),
        .ext_hrdata    (hrdata       ),
        .us_hready     (us_hready    ),
        .us_hresp      (us_hresp     ),
        .us_hrdata     (us_hrdata    )
    );

    ahb_rom_bridge u_rom_bridge (
        .hclk      (hclk           ),
        .hresetn   (hresetn        ),
        .sel       (rom_sel        ),
        .ready     (us_hready      ),
        .htrans    (us_htrans      ),
        .hwrite    (us_hwrite      ),
        .haddr     (us_haddr[15:0] ),
        .hreadyout (rom_hreadyout  ),
        .hresp     (rom_hresp      ),
        .rom_ce    (rom_ce         ),
        .rom_addr  (rom_addr       )
    );

    boot_rom u_boot_rom (
        .hclk  (hclk     ),
        .ce    (rom_ce   ),
        .addr  (rom_addr ),
        .rdata (rom_rdata)
    );

    irq_sync #(.width(`IRQ_NUM)) u_irq_sync (
        .hclk     (hclk     ),
        .hresetn  (hresetn  ),
        .async_in (int_src  ),
        .level    (irq_level),
        .rise     (         )
    );

    irq_sync #(.width(1)) u_nmi_sync (
        .hclk     (hclk    ),
        .hresetn  (hresetn ),
        .async_in (nmi     ),
        .level    (        ),
        .rise     (nmi_req )
    );

    // a ROM read issued by the bridge lands in a zero-wait ROM data phase
    rom_read_no_wait: assert property (@(posedge hclk) disable iff (!hresetn)
        rom_ce |=> (u_decoder.owner_q == SEL_ROM) && us_hready);

endmodule

`default_nettype wire

// ==== rtl/irq_sync.sv ====
// synchronizer bank that brings async interrupt lines into hclk and flags their rising edges
`timescale 1ns/1ps
`default_nettype none
`include "cpu_subsys_defines.svh"

module irq_sync #(
    parameter int width = 1
) (
    input  logic             hclk,
    input  logic             hresetn,
    input  logic [width-1:0] async_in,
    output logic [width-1:0] level,
    output logic [width-1:0] rise
);

    logic [width-1:0] sync_q [`SYNC_STAGES];
    logic [width-1:0] level_d;

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            for (int i = 0; i < `SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            level_d <= '0;
        end else begin
            sync_q[0] <= async_in;                  // may go metastable
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            level_d <= sync_q[`SYNC_STAGES-1];      // edge detect history
        end
    end

    assign level = sync_q[`SYNC_STAGES-1];
    assign rise  = level & ~level_d;

    // a pulse only on a bit that just went high
    rise_is_edge: assert property (@(posedge hclk) disable iff (!hresetn)
        (|rise) |-> ((rise & level) == rise) && ((rise & $past(level)) == '0));

endmodule

`default_nettype wire

// ==== tests/boot_rom.hex ====
// boot ROM image, one 32-bit word per line, starting at word address 0
00000297
02028293
30529073
00000517
01450513
000015b7
80058593
00b52023
10500073
ffdff06f
0badc0de
12345678
9abcdef0
5a5aa5a5
00ff00ff
cafef00d

// ==== tests/cpu_subsystem_tb.sv ====
// testbench for the CPU subsystem, plays the core master and an external AHB slave
`timescale 1ns/1ps
`default_nettype none
`include "cpu_subsys_defines.svh"

module cpu_subsystem_tb
    import cpu_subsys_pkg::*;
();

    localparam int max_cycles = 4000;               // generous bound on the whole run

    logic              hclk;
    logic              hresetn;
    logic [31:0]       us_haddr;
    htrans_e           us_htrans;
    logic              us_hwrite;
    logic [2:0]        us_hsize;
    logic [2:0]        us_hburst;
    logic [3:0]        us_hprot;
    logic [31:0]       us_hwdata;
    logic [31:0]       us_hrdata;
    logic              us_hready;
    hresp_e            us_hresp;
    logic [31:0]       haddr;
    logic              hsel;
    htrans_e           htrans;
    logic              hwrite;
    logic [2:0]        hsize;
    logic [2:0]        hburst;
    logic [3:0]        hprot;
    logic [31:0]       hwdata;
    logic [31:0]       hrdata;
    logic              hready;
    hresp_e            hresp;
    logic [`IRQ_NUM:1] int_src;
    logic              nmi;
    logic [`IRQ_NUM:1] irq_level;
    logic              nmi_req;

    // same words as the ROM image file
    logic [31:0] rom_image [16] = '{
        32'h00000297, 32'h02028293, 32'h30529073, 32'h00000517,
        32'h01450513, 32'h000015b7, 32'h80058593, 32'h00b52023,
        32'h10500073, 32'hffdff06f, 32'h0badc0de, 32'h12345678,
        32'h9abcdef0, 32'h5a5aa5a5, 32'h00ff00ff, 32'hcafef00d
    };

    logic              dp_valid;                    // master's view of the data phase
    logic              dp_rom;
    logic              dp_write;
    logic [31:0]       dp_addr;
    int                dp_cyc;
    logic [`IRQ_NUM:1] int_d1;
    logic [`IRQ_NUM:1] int_d2;
    logic              nmi_d1;
    logic              nmi_d2;
    logic              nmi_d3;
    logic              exp_hsel;
    logic              exp_ready;
    hresp_e            exp_resp;
    logic [31:0]       exp_rdata;
    int                ext_wait = 0;
    logic [31:0]       ext_addr = '0;
    logic              ext_err = 1'b0;
    integer            seed = 19992;
    int                errors = 0;
    int                xfers = 0;
    int                nmi_edges = 0;
    int                nmi_pulses = 0;
    int                cycle_cnt;

    cpu_subsystem dut (.*);

    function automatic logic [31:0] rand_bits();
        return $random(seed);
    endfunction

    function automatic logic [31:0] ext_word(input logic [31:0] addr);
        return {addr[15:0], ~addr[15:0]} ^ 32'h1357_9BDF;
    endfunction

    function automatic logic [31:0] wr_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0F0F;
    endfunction

    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        if (addr[15:6] != '0) begin
            return 32'h0;                           // outside the image, zero filled
        end
        return rom_image[addr[5:2]];
    endfunction

    task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    endtask

    task automatic note_fail(input string msg);
        errors++;
        $display("%0t %s", $time, msg);
    endtask

    // address phase, returns at the edge that accepts it
    task automatic issue(input logic [31:0] addr, input logic write);
        @(negedge hclk);
        us_haddr  = addr;
        us_htrans = TRANS_NONSEQ;
        us_hwrite = write;
        us_hprot  = addr[5:2];
        @(posedge hclk);
        while (!us_hready) @(posedge hclk);
        xfers++;
    endtask

    task automatic finish_bus();
        @(negedge hclk);
        us_htrans = TRANS_IDLE;
        us_hwrite = 1'b0;
        @(posedge hclk);
        while (!us_hready) @(posedge hclk);
    endtask

    task automatic drive_irq(input int n);
        logic [31:0] rnd;
        repeat (n) begin
            @(negedge hclk);
            rnd     = rand_bits();
            int_src = rnd[`IRQ_NUM-1:0];
            repeat (rnd[31:30]) @(negedge hclk);    // hold 0 to 3 extra cycles
        end
    endtask

    task automatic pulse_nmi(input int high_cycles, input int low_cycles);
        @(negedge hclk);
        nmi = 1'b1;
        nmi_edges++;
        repeat (high_cycles) @(negedge hclk);
        nmi = 1'b0;
        repeat (low_cycles) @(negedge hclk);
    endtask

    initial begin
        hclk = 1'b0;
        forever #10 hclk = ~hclk;
    end

    // data-phase tracker and input history
    always @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            dp_valid   <= 1'b0;
            dp_rom     <= 1'b0;
            dp_write   <= 1'b0;
            dp_addr    <= '0;
            dp_cyc     <= 0;
            {int_d1, int_d2} <= '0;
            {nmi_d1, nmi_d2, nmi_d3} <= '0;
        end else begin
            if (us_hready) begin
                dp_valid <= (us_htrans == TRANS_NONSEQ) || (us_htrans == TRANS_SEQ);
                dp_rom   <= (us_haddr[31:16] == `ROM_ADDR_TAG);
                dp_write <= us_hwrite;
                dp_addr  <= us_haddr;
                dp_cyc   <= 0;
            end else begin
                dp_cyc <= dp_cyc + 1;
            end
            int_d1 <= int_src;
            int_d2 <= int_d1;
            {nmi_d3, nmi_d2, nmi_d1} <= {nmi_d2, nmi_d1, nmi};
            if (nmi_req) begin
                nmi_pulses <= nmi_pulses + 1;
            end
        end
    end

    // external slave, 0 to 3 wait states, two-cycle ERROR on writes with haddr[5] set
    always @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ext_wait <= 0;
            ext_err  <= 1'b0;
        end else if (hsel && us_hready) begin
            ext_err  <= hwrite && haddr[5];
            ext_wait <= (rand_bits() & 3) + (hwrite && haddr[5]);
            ext_addr <= haddr;
        end else if (ext_wait != 0) begin
            ext_wait <= ext_wait - 1;
        end else if (us_hready) begin
            ext_err <= 1'b0;
        end
    end

    always @(negedge hclk) begin
        hready    = (ext_wait == 0);
        hresp     = (ext_err && ext_wait <= 1) ? RESP_ERROR : RESP_OKAY;
        hrdata    = ext_word(ext_addr);
        us_hwdata = dp_write ? wr_word(dp_addr) : 32'h0;   // master write data
    end

    assign exp_hsel = (us_htrans == TRANS_NONSEQ || us_htrans == TRANS_SEQ)
                      && (us_haddr[31:16] != `ROM_ADDR_TAG);

    always_comb begin
        exp_ready = 1'b1;
        exp_resp  = RESP_OKAY;
        exp_rdata = '0;
        if (dp_valid && dp_rom) begin
            exp_ready = !(dp_write && dp_cyc == 0);     // first ERROR cycle waits
            exp_resp  = dp_write ? RESP_ERROR : RESP_OKAY;
            exp_rdata = rom_word(dp_addr);
        end else if (dp_valid) begin
            exp_ready = hready;
            exp_resp  = hresp;
            exp_rdata = ext_word(dp_addr);
        end
    end

    reset_state: assert property (@(posedge hclk)
        !hresetn |-> us_hready && us_hresp == RESP_OKAY && !hsel && irq_level == '0 && !nmi_req)
        else note_fail("outputs are not in their reset state during reset");

    hsel_decode: assert property (@(posedge hclk) disable iff (!hresetn) hsel == exp_hsel)
        else value_fail("hsel", $sampled(hsel), $sampled(exp_hsel));

    ext_addr_pass: assert property (@(posedge hclk) disable iff (!hresetn)
        hsel |-> haddr == us_haddr)
        else value_fail("haddr", $sampled(haddr), $sampled(us_haddr));

    ext_ctrl_pass: assert property (@(posedge hclk) disable iff (!hresetn)
        hsel |-> {htrans, hwrite, hsize, hburst, hprot}
                 == {us_htrans, us_hwrite, us_hsize, us_hburst, us_hprot})
        else value_fail("htrans/hwrite/hsize/hburst/hprot",
                        $sampled({htrans, hwrite, hsize, hburst, hprot}),
                        $sampled({us_htrans, us_hwrite, us_hsize, us_hburst, us_hprot}));

    ext_wdata_pass: assert property (@(posedge hclk) disable iff (!hresetn)
        dp_valid && !dp_rom && dp_write |-> hwdata == wr_word(dp_addr))
        else value_fail("hwdata", $sampled(hwdata), wr_word($sampled(dp_addr)));

    ready_ok: assert property (@(posedge hclk) disable iff (!hresetn) us_hready == exp_ready)
        else value_fail("us_hready", $sampled(us_hready), $sampled(exp_ready));

    resp_ok: assert property (@(posedge hclk) disable iff (!hresetn) us_hresp == exp_resp)
        else value_fail("us_hresp", $sampled(us_hresp), $sampled(exp_resp));

    rdata_ok: assert property (@(posedge hclk) disable iff (!hresetn)
        (!dp_valid || (!dp_write && us_hready)) |-> us_hrdata == exp_rdata)
        else value_fail("us_hrdata", $sampled(us_hrdata), $sampled(exp_rdata));

    irq_delay: assert property (@(posedge hclk) disable iff (!hresetn) irq_level == int_d2)
        else value_fail("irq_level", $sampled(irq_level), $sampled(int_d2));

    nmi_pulse: assert property (@(posedge hclk) disable iff (!hresetn)
        nmi_req == (nmi_d2 && !nmi_d3))
        else value_fail("nmi_req", $sampled(nmi_req), $sampled(nmi_d2 && !nmi_d3));

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge hclk);
            cycle_cnt++;
        end
        $display("timeout: the test sequence did not end within %0d cycles", max_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        hresetn   = 1'b0;
        us_haddr  = '0;
        us_htrans = TRANS_IDLE;
        us_hwrite = 1'b0;
        us_hsize  = 3'b010;
        us_hburst = 3'b000;
        us_hprot  = 4'h0;
        us_hwdata = '0;
        hrdata    = '0;
        hready    = 1'b1;
        hresp     = RESP_OKAY;
        int_src   = '0;
        nmi       = 1'b0;
        repeat (8) @(negedge hclk);
        hresetn = 1'b1;
        repeat (3) @(negedge hclk);
        us_haddr  = 32'h0000_1000;
        us_htrans = TRANS_BUSY;                     // selects nobody
        @(negedge hclk);
        us_htrans = TRANS_IDLE;
        for (int i = 0; i < 16; i++) begin
            issue(32'hFFFF_0000 + 4 * i, 1'b0);
            finish_bus();
        end
        for (int i = 15; i >= 0; i--) begin
            issue(32'hFFFF_0000 + 4 * i, 1'b0);     // back to back ROM reads
        end
        finish_bus();
        for (int i = 0; i < 8; i++) begin
            issue(32'h2000_0000 + 16 * i, i[0]);
            finish_bus();
        end
        for (int i = 0; i < 8; i++) begin
            issue(32'h4000_0100 + 4 * i, i[1]);     // next address waits out the slave
        end
        issue(32'hFFFE_FFFC, 1'b0);
        issue(32'hFFFF_003C, 1'b0);
        issue(32'hFFFF_0010, 1'b1);                 // ROM write right after a read
        finish_bus();
        issue(32'hFFFF_0020, 1'b1);
        issue(32'hFFFF_0024, 1'b1);                 // accepted in the closing ERROR cycle
        issue(32'h0000_0040, 1'b1);
        finish_bus();
        repeat (4) @(negedge hclk);
        drive_irq(20);
        pulse_nmi(1, 1);
        pulse_nmi(3, 2);
        pulse_nmi(1, 4);
        pulse_nmi(6, 1);
        repeat (6) @(negedge hclk);
        if (nmi_pulses != nmi_edges) begin
            note_fail("number of nmi_req pulses differs from the number of NMI rising edges");
        end
        $display("transfers %0d, nmi edges %0d, nmi pulses %0d, errors %0d",
                 xfers, nmi_edges, nmi_pulses, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
